//--- run_sim.sh
#!/bin/sh
# build and run the data_io testbench with verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_data_io \
    -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_data_io > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Everything OK" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- source/data_io.sv
// ****************************************
// spi slave top level between the io
// controller and the core
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module data_io
    import data_io_pkg::*;
(
    input  logic                   SPI_SCK,
    input  logic                   SPI_SS2,
    input  logic                   SPI_DI,
    output logic                   SPI_DO,
    // byte returned by command 0x10
    input  byte_t                  data_in,
    // external config string rom
    output logic [conf_addr_w-1:0] conf_addr,
    input  byte_t                  conf_chr,
    output status_t                status,
    output config_array_t          config_buffer,
    output core_mod_t              core_mod,
    // file download into the core
    input  logic                   clk_rom,
    output logic                   ioctl_download,
    output byte_t                  ioctl_index,
    output logic                   ioctl_wr,
    output dl_addr_t               ioctl_addr,
    output byte_t                  ioctl_dout
);

    byte_t    cmd;
    bit_cnt_t bit_cnt;
    logic     wr_level;
    dl_addr_t wr_addr;
    byte_t    wr_data;

    dl_write_if dl_bus ();

    spi_cmd_rx spi_cmd_rx_i (
        .SPI_SCK        (SPI_SCK),
        .SPI_SS2        (SPI_SS2),
        .SPI_DI         (SPI_DI),
        .cmd            (cmd),
        .bit_cnt        (bit_cnt),
        .status         (status),
        .core_mod       (core_mod),
        .config_buffer  (config_buffer),
        .ioctl_index    (ioctl_index),
        .ioctl_download (ioctl_download),
        .dl             (dl_bus)
    );

    spi_tx_shifter spi_tx_shifter_i (
        .SPI_SCK   (SPI_SCK),
        .SPI_SS2   (SPI_SS2),
        .cmd       (cmd),
        .bit_cnt   (bit_cnt),
        .data_in   (data_in),
        .conf_chr  (conf_chr),
        .SPI_DO    (SPI_DO),
        .conf_addr (conf_addr)
    );

    // spi clock side of the download path
    dl_addr_buffer dl_addr_buffer_i (
        .SPI_SCK  (SPI_SCK),
        .SPI_SS2  (SPI_SS2),
        .dl       (dl_bus),
        .wr_level (wr_level),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    // rom clock side, needs clk_rom at least 3x SPI_SCK
    ioctl_wr_sync ioctl_wr_sync_i (
        .clk_rom    (clk_rom),
        .wr_level   (wr_level),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .ioctl_wr   (ioctl_wr),
        .ioctl_addr (ioctl_addr),
        .ioctl_dout (ioctl_dout)
    );

endmodule

`default_nettype wire

//--- source/data_io_pkg.sv
// ****************************************
// command codes, widths and shared types
// for the io controller spi slave
// ****************************************
`default_nettype none

package data_io_pkg;

    // one byte on the link
    typedef logic [7:0] byte_t;

    // command codes, first byte of a frame
    localparam byte_t cmd_ack        = 8'h00;
    localparam byte_t cmd_data_rd    = 8'h10;
    localparam byte_t cmd_conf_rd    = 8'h14;
    localparam byte_t cmd_status     = 8'h15;
    localparam byte_t cmd_file_index = 8'h55;
    localparam byte_t cmd_conf_wr    = 8'h60;
    localparam byte_t cmd_dl_start   = 8'h61;
    localparam byte_t cmd_dl_end     = 8'h62;

    // reply to the acknowledge command, letter K
    localparam byte_t ack_byte = 8'h4b;

    localparam int dl_addr_w    = 25;
    localparam int conf_addr_w  = 10;
    localparam int conf_entries = 16;
    // width of the descending operand counter
    localparam int conf_idx_w   = $clog2(conf_entries);

    typedef logic [dl_addr_w-1:0] dl_addr_t;
    typedef logic [31:0]          status_t;
    typedef logic [6:0]           core_mod_t;
    // counts 0..15 then 8..15 repeatedly
    typedef logic [4:0]           bit_cnt_t;
    typedef byte_t [conf_entries-1:0] config_array_t;

endpackage

`default_nettype wire

//--- source/dl_addr_buffer.sv
// ****************************************
// download address counter, byte capture
// and single cycle write level
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module dl_addr_buffer
    import data_io_pkg::*;
(
    input  logic      SPI_SCK,
    input  logic      SPI_SS2,
    dl_write_if.buff  dl,
    output logic      wr_level,
    output dl_addr_t  wr_addr,
    output byte_t     wr_data
);

    // address of the next byte to be written
    dl_addr_t addr  = '0;
    logic     level = 1'b0;

    always_ff @(posedge SPI_SCK)
    begin
        // one spi clock high per pumped byte
        level <= dl.byte_valid;

        // byte and address stay put until the next pump
        if (dl.byte_valid)
        begin
            wr_data <= dl.pump_byte;
            wr_addr <= addr;
        end

        // restart at zero on a new download or config write
        if (dl.dl_start || dl.addr_clear)
            addr <= '0;
        else if (level)
            addr <= addr + 1'b1;
    end

    assign wr_level = level;

    // the rom side sees exactly one rise per byte
    a_level_single: assert property (@(posedge SPI_SCK) disable iff (SPI_SS2)
        wr_level |=> !wr_level);

endmodule

`default_nettype wire

//--- source/dl_write_if.sv
// ****************************************
// download events from the command
// receiver to the address buffer
// ****************************************
`timescale 1ns/100ps
`default_nettype none

interface dl_write_if
    import data_io_pkg::*;
();
    // one spi clock when command 0x61 is decoded
    logic  dl_start   = 1'b0;
    // one spi clock per configuration operand byte
    logic  addr_clear = 1'b0;
    // one spi clock per pumped download byte
    logic  byte_valid = 1'b0;
    // the pumped byte held until the next one
    byte_t pump_byte;

    modport rx (
        output dl_start,
        output addr_clear,
        output byte_valid,
        output pump_byte
    );

    // address buffer side
    modport buff (
        input dl_start,
        input addr_clear,
        input byte_valid,
        input pump_byte
    );

endinterface

`default_nettype wire

//--- source/ioctl_wr_sync.sv
// ****************************************
// rom clock synchronizer, edge detector
// and write strobe shaper
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module ioctl_wr_sync
    import data_io_pkg::*;
(
    input  logic     clk_rom,
    input  logic     wr_level,
    input  dl_addr_t wr_addr,
    input  byte_t    wr_data,
    output logic     ioctl_wr,
    output dl_addr_t ioctl_addr,
    output byte_t    ioctl_dout
);

    // two stage synchronizer plus one flop for edge detection
    logic lvl_meta = 1'b0;
    logic lvl_sync = 1'b0;
    logic lvl_prev = 1'b0;
    logic lvl_rise;
    // load done, strobe goes out next cycle
    logic wr_pend  = 1'b0;
    logic wr_q     = 1'b0;

    assign lvl_rise = lvl_sync & ~lvl_prev;

    always_ff @(posedge clk_rom)
    begin
        lvl_meta <= wr_level;
        lvl_sync <= lvl_meta;
        lvl_prev <= lvl_sync;
        wr_pend  <= lvl_rise;
        wr_q     <= wr_pend;

        // spi side holds address and data long past this point
        if (lvl_rise)
        begin
            ioctl_addr <= wr_addr;
            ioctl_dout <= wr_data;
        end
    end

    assign ioctl_wr = wr_q;

    a_wr_single: assert property (@(posedge clk_rom) ioctl_wr |=> !ioctl_wr);

endmodule

`default_nettype wire

//--- source/spi_cmd_rx.sv
// ****************************************
// spi rising edge shifter, command decoder
// and operand registers
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_rx
    import data_io_pkg::*;
(
    input  logic          SPI_SCK,
    input  logic          SPI_SS2,
    input  logic          SPI_DI,
    output byte_t         cmd,
    output bit_cnt_t      bit_cnt,
    output status_t       status,
    output core_mod_t     core_mod,
    output config_array_t config_buffer,
    output byte_t         ioctl_index,
    output logic          ioctl_download,
    dl_write_if.rx        dl
);

    // seven bits are shifted in, the eighth is taken straight from SPI_DI
    logic [6:0]            sbuf;
    byte_t                 rx_byte;
    logic                  cmd_done;
    logic                  op_done;
    // selects the target of each operand byte, counts down from 15
    logic [conf_idx_w-1:0] conf_idx;

    // these survive the end of a frame
    status_t       status_r   = '0;
    core_mod_t     core_mod_r = '0;
    config_array_t conf_r     = '0;
    logic          dl_flag    = 1'b0;

    assign rx_byte  = {sbuf, SPI_DI};
    // 8th rising edge after select
    assign cmd_done = (bit_cnt == 5'd7);
    // every later 8th edge
    assign op_done  = (bit_cnt == 5'd15);

    // frame control, cleared while deselected
    always_ff @(posedge SPI_SCK or posedge SPI_SS2)
    begin
        if (SPI_SS2)
        begin
            bit_cnt     <= '0;
            cmd         <= '0;
            conf_idx    <= '1;
            ioctl_index <= '0;
        end
        else
        begin
            // 0..15 for command and first operand, then 8..15 per byte
            if (bit_cnt < 5'd15)
                bit_cnt <= bit_cnt + 5'd1;
            else
                bit_cnt <= 5'd8;

            if (cmd_done)
                cmd <= rx_byte;

            // next operand goes one entry lower
            if (op_done && ((cmd == cmd_status) || (cmd == cmd_conf_wr)))
                conf_idx <= conf_idx - 1'b1;

            if (op_done && (cmd == cmd_file_index))
                ioctl_index <= rx_byte;
        end
    end

    // shifter, operand storage and download events
    always_ff @(posedge SPI_SCK)
    begin
        sbuf <= {sbuf[5:0], SPI_DI};

        // event strobes, self clearing after one spi clock
        dl.dl_start   <= cmd_done && (rx_byte == cmd_dl_start);
        dl.addr_clear <= op_done && (cmd == cmd_conf_wr);
        dl.byte_valid <= op_done && (cmd == cmd_dl_start);

        if (op_done && (cmd == cmd_dl_start))
            dl.pump_byte <= rx_byte;

        // download flag spans frames until 0x62
        if (cmd_done && (rx_byte == cmd_dl_start))
            dl_flag <= 1'b1;
        else if (cmd_done && (rx_byte == cmd_dl_end))
            dl_flag <= 1'b0;

        // status word msb first, then the variant byte
        if (op_done && (cmd == cmd_status))
        begin
            case (conf_idx)
                4'd15: status_r[31:24] <= rx_byte;
                4'd14: status_r[23:16] <= rx_byte;
                4'd13: status_r[15:8]  <= rx_byte;
                4'd12: status_r[7:0]   <= rx_byte;
                4'd11: core_mod_r      <= rx_byte[6:0];
                default: ;
            endcase
        end

        if (op_done && (cmd == cmd_conf_wr))
            conf_r[conf_idx] <= rx_byte;
    end

    assign status         = status_r;
    assign core_mod       = core_mod_r;
    assign config_buffer  = conf_r;
    assign ioctl_download = dl_flag;

    // counter wraps back to 8, never past 15
    a_bit_cnt_range: assert property (@(posedge SPI_SCK) bit_cnt <= 5'd15);

    // a pumped byte only inside an open download
    a_pump_in_dl: assert property (@(posedge SPI_SCK) dl.byte_valid |-> ioctl_download);

endmodule

`default_nettype wire

//--- source/spi_tx_shifter.sv
// ****************************************
// spi falling edge reply serializer and
// config string address counter
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module spi_tx_shifter
    import data_io_pkg::*;
(
    input  logic                   SPI_SCK,
    input  logic                   SPI_SS2,
    input  byte_t                  cmd,
    input  bit_cnt_t               bit_cnt,
    input  byte_t                  data_in,
    input  byte_t                  conf_chr,
    output logic                   SPI_DO,
    output logic [conf_addr_w-1:0] conf_addr
);

    byte_t tx_byte;
    // high when the command has a reply
    logic  tx_sel;
    logic  sdo_bit;
    logic  sdo_oe;

    always_comb
    begin
        tx_sel  = 1'b1;
        tx_byte = '0;
        case (cmd)
            cmd_ack:     tx_byte = ack_byte;
            cmd_data_rd: tx_byte = data_in;
            cmd_conf_rd: tx_byte = conf_chr;
            default:     tx_sel  = 1'b0;
        endcase
    end

    // output enable and string address, cleared while deselected
    always_ff @(negedge SPI_SCK or posedge SPI_SS2)
    begin
        if (SPI_SS2)
        begin
            sdo_oe    <= 1'b0;
            conf_addr <= '0;
        end
        else
        begin
            sdo_oe <= 1'b1;
            // step after the last bit of each string byte
            if (cmd == cmd_conf_rd)
            begin
                if (bit_cnt[2:0] == 3'd7)
                    conf_addr <= conf_addr + 1'b1;
            end
            else
                conf_addr <= '0;
        end
    end

    // msb first, other commands keep the last bit
    always_ff @(negedge SPI_SCK)
    begin
        if (tx_sel)
            sdo_bit <= tx_byte[~bit_cnt[2:0]];
    end

    assign SPI_DO = sdo_oe ? sdo_bit : 1'bz;

endmodule

`default_nettype wire

//--- testbench/tb_data_io.sv
// ****************************************
// directed testbench for the spi slave
// spi master tasks, rom model, checks
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module tb_data_io
    import data_io_pkg::*;
();

    // spi clock idles high and falls first at 10 ns
    logic                   spi_sck = 1'b1;
    logic                   clk_rom = 1'b0;
    // select starts low so that its first rise resets the frame logic
    logic                   spi_ss2 = 1'b0;
    logic                   spi_di  = 1'b0;
    byte_t                  data_in = '0;
    wire                    spi_do;
    logic [conf_addr_w-1:0] conf_addr;
    byte_t                  conf_chr;
    status_t                status;
    config_array_t          config_buffer;
    core_mod_t              core_mod;
    logic                   ioctl_download;
    byte_t                  ioctl_index;
    logic                   ioctl_wr;
    dl_addr_t               ioctl_addr;
    byte_t                  ioctl_dout;

    // expected download writes in order
    dl_addr_t    exp_addr_q[$];
    byte_t       exp_data_q[$];
    byte_t       tx_buf[32];
    byte_t       rx_buf[32];
    logic [31:0] lfsr   = 32'h09024e50;
    int          cycles = 0;

    always #10 spi_sck = ~spi_sck;
    // 4x the spi clock to meet the 3x minimum of the sync
    always #2.5 clk_rom = ~clk_rom;

    // config string rom model
    assign conf_chr = conf_addr[7:0] + 8'h30;

    data_io data_io_i (
        .SPI_SCK        (spi_sck),
        .SPI_SS2        (spi_ss2),
        .SPI_DI         (spi_di),
        .SPI_DO         (spi_do),
        .data_in        (data_in),
        .conf_addr      (conf_addr),
        .conf_chr       (conf_chr),
        .status         (status),
        .config_buffer  (config_buffer),
        .core_mod       (core_mod),
        .clk_rom        (clk_rom),
        .ioctl_download (ioctl_download),
        .ioctl_index    (ioctl_index),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout)
    );

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] t=%0t %s: expected %h, actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input status_t expected,
                                input status_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] t=%0t %s: expected %h, actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_core_mod(input string name, input core_mod_t expected,
                                  input core_mod_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] t=%0t %s: expected %h, actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input dl_addr_t expected,
                              input dl_addr_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] t=%0t %s: expected %h, actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[ERROR] t=%0t %s: expected %b, actual %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per payload bit
    task automatic rand_byte(output byte_t b);
        b = '0;
        for (int i = 0; i < 8; i++)
        begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    // msb first with data driven on the falling edge and the reply sampled on the rising edge
    task automatic xfer_byte(input byte_t tx, output byte_t rx);
        for (int i = 7; i >= 0; i--)
        begin
            @(negedge spi_sck);
            spi_ss2 <= 1'b0;
            spi_di  <= tx[i];
            @(posedge spi_sck);
            rx[i] = spi_do;
        end
    endtask

    // deselect and idle long enough for the last rom write
    task automatic end_frame();
        @(negedge spi_sck);
        spi_ss2 <= 1'b1;
        repeat (4) @(negedge spi_sck);
    endtask

    task automatic run_frame(input int n);
        for (int k = 0; k < n; k++)
            xfer_byte(tx_buf[k], rx_buf[k]);
        end_frame();
    endtask

    task automatic wait_writes();
        while (exp_addr_q.size() != 0)
            @(posedge clk_rom);
    endtask

    task automatic test_ack_and_data();
        byte_t b;
        tx_buf[0] = cmd_ack;
        tx_buf[1] = 8'h00;
        run_frame(2);
        check_byte("SPI_DO ack reply", ack_byte, rx_buf[1]);
        rand_byte(b);
        @(negedge spi_sck);
        data_in <= b;
        tx_buf[0] = cmd_data_rd;
        run_frame(2);
        check_byte("SPI_DO data reply", b, rx_buf[1]);
    endtask

    // rom returns address plus 0x30 and the string starts at address 0
    task automatic test_conf_string();
        tx_buf[0] = cmd_conf_rd;
        for (int k = 1; k <= 4; k++)
            tx_buf[k] = 8'h00;
        run_frame(5);
        for (int k = 1; k <= 4; k++)
            check_byte($sformatf("SPI_DO conf byte %0d", k - 1), 8'h30 + byte_t'(k - 1),
                       rx_buf[k]);
        check_addr("conf_addr", '0, dl_addr_t'(conf_addr));
    endtask

    task automatic test_status();
        tx_buf[0] = cmd_status;
        for (int k = 1; k <= 5; k++)
            rand_byte(tx_buf[k]);
        run_frame(6);
        check_status("status", {tx_buf[1], tx_buf[2], tx_buf[3], tx_buf[4]}, status);
        check_core_mod("core_mod", tx_buf[5][6:0], core_mod);
    endtask

    task automatic test_config_and_index();
        byte_t b;
        byte_t r;
        tx_buf[0] = cmd_conf_wr;
        for (int k = 1; k <= 16; k++)
            rand_byte(tx_buf[k]);
        run_frame(17);
        // first operand lands in entry 15
        for (int k = 0; k < 16; k++)
            check_byte($sformatf("config_buffer[%0d]", 15 - k), tx_buf[k + 1],
                       config_buffer[15 - k]);
        rand_byte(b);
        xfer_byte(cmd_file_index, r);
        xfer_byte(b, r);
        @(negedge spi_sck);
        check_byte("ioctl_index", b, ioctl_index);
        end_frame();
        // index only lives within its frame
        xfer_byte(cmd_ack, r);
        @(negedge spi_sck);
        check_byte("ioctl_index", 8'h00, ioctl_index);
        end_frame();
    endtask

    task automatic download_frame(input int n);
        tx_buf[0] = cmd_dl_start;
        for (int k = 1; k <= n; k++)
        begin
            rand_byte(tx_buf[k]);
            exp_addr_q.push_back(dl_addr_t'(k - 1));
            exp_data_q.push_back(tx_buf[k]);
        end
        run_frame(n + 1);
        check_bit("ioctl_download", 1'b1, ioctl_download);
        wait_writes();
    endtask

    task automatic test_download();
        check_bit("ioctl_download", 1'b0, ioctl_download);
        download_frame(8);
        // a new download starts again at address 0
        download_frame(5);
        tx_buf[0] = cmd_dl_end;
        run_frame(1);
        check_bit("ioctl_download", 1'b0, ioctl_download);
        repeat (20) @(negedge spi_sck);
    endtask

    // one falling edge of clk_rom sees each single cycle ioctl_wr pulse
    always @(negedge clk_rom)
    begin
        if (ioctl_wr === 1'b1)
        begin
            if (exp_addr_q.size() == 0)
            begin
                $display("ioctl_wr pulse at t=%0t with no download byte pending", $time);
                abort_run();
            end
            else
            begin
                check_addr("ioctl_addr", exp_addr_q.pop_front(), ioctl_addr);
                check_byte("ioctl_dout", exp_data_q.pop_front(), ioctl_dout);
            end
        end
    end

    // whole run takes well under 1000 spi clocks
    always @(posedge spi_sck)
    begin
        cycles <= cycles + 1;
        if (cycles >= 4000)
        begin
            $display("timeout, run did not finish within %0d SPI_SCK cycles", cycles);
            abort_run();
        end
    end

    initial
    begin
        @(negedge spi_sck);
        spi_ss2 <= 1'b1;
        // the first frame's own falling edge ends the fifth cycle
        repeat (4) @(negedge spi_sck);
        test_ack_and_data();
        test_conf_string();
        test_status();
        test_config_and_index();
        test_download();
        if (exp_addr_q.size() != 0)
        begin
            $display("%0d download writes never reached ioctl_wr", exp_addr_q.size());
            abort_run();
        end
        else
        begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
source/data_io_pkg.sv
source/dl_write_if.sv
source/spi_cmd_rx.sv
source/spi_tx_shifter.sv
source/dl_addr_buffer.sv
source/ioctl_wr_sync.sv
source/data_io.sv
testbench/tb_data_io.sv
